//--- Bender.yml
package:
  name: hero

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/hero_pkg.sv
      - rtl/cl_port_arbiter.sv
      - rtl/soc_router.sv
      - rtl/l2_mem.sv
      - rtl/rab.sv
      - rtl/hero.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/tb_hero.sv

//--- include/hero_defs.svh
/*
 * HERO SoC constants
 * sizes of the cluster ports, the L2 scratchpad and the RAB table,
 * and the address region codes
 */
`ifndef HERO_DEFS_SVH
`define HERO_DEFS_SVH

// number of cluster request ports (2 to 8)
`define HERO_N_CLUSTERS 4

// L2 depth in 32-bit words
`define HERO_L2_WORDS 256

// RAB translation entries
`define HERO_RAB_ENTRIES 4

// region code in addr[31:28] that selects the L2
`define HERO_REGION_L2 4'h1

`endif

//--- rtl/cl_port_arbiter.sv
/*
 * cluster port arbiter
 * round-robin grant of the cluster req/ack ports onto one internal port,
 * grant held for the whole four-phase handshake
 */
`timescale 1ns/1ns
`include "hero_defs.svh"

module cl_port_arbiter #(
  parameter int unsigned N_CLUSTERS = `HERO_N_CLUSTERS
) (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  logic              [N_CLUSTERS-1:0] cl_req_valid_i,
  input  hero_pkg::cl_req_t [N_CLUSTERS-1:0] cl_req_i,
  output logic              [N_CLUSTERS-1:0] cl_ack_o,
  output hero_pkg::cl_rsp_t                   cl_rsp_o,
  output logic                                bus_req_o,
  output hero_pkg::cl_req_t                   bus_pl_o,
  input  logic                                bus_ack_i,
  input  hero_pkg::cl_rsp_t                   bus_rsp_i
);

  localparam int unsigned PW = $clog2(N_CLUSTERS);

  logic          busy_q;
  logic [PW-1:0] grant_q;
  logic [PW-1:0] ptr_q;
  logic [PW-1:0] pick_idx;
  logic          pick_found;
  int unsigned   cand;

  // first requester at or after the pointer
  always_comb begin
    pick_found = 1'b0;
    pick_idx   = '0;
    cand       = 0;
    for (int unsigned i = 0; i < N_CLUSTERS; i++) begin
      cand = int'(ptr_q) + i;
      if (cand >= N_CLUSTERS) begin
        cand = cand - N_CLUSTERS;
      end
      if (!pick_found && cl_req_valid_i[cand]) begin
        pick_found = 1'b1;
        pick_idx   = PW'(cand);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q  <= 1'b0;
      grant_q <= '0;
      ptr_q   <= '0;
    end else if (!busy_q) begin
      if (pick_found) begin
        busy_q  <= 1'b1;
        grant_q <= pick_idx;
      end
    end else if (!cl_req_valid_i[grant_q] && !bus_ack_i) begin
      // handshake closed so the pointer moves past the winner
      busy_q <= 1'b0;
      ptr_q  <= (grant_q == PW'(N_CLUSTERS - 1)) ? '0 : grant_q + 1'b1;
    end
  end

  assign bus_req_o = busy_q && cl_req_valid_i[grant_q];
  assign bus_pl_o  = cl_req_i[grant_q];
  assign cl_rsp_o  = bus_rsp_i;

  // ack only reaches the granted cluster
  always_comb begin
    cl_ack_o          = '0;
    cl_ack_o[grant_q] = busy_q && bus_ack_i;
  end

endmodule

//--- rtl/hero.sv
/*
 * HERO accelerator SoC top
 * cluster ports arbitrated onto one SoC bus, routed to the L2
 * scratchpad or through the RAB to the host
 */
`timescale 1ns/1ns
`include "hero_defs.svh"

module hero (
  input  logic                                        clk_i,
  input  logic                                        rst_n_i,
  input  logic              [`HERO_N_CLUSTERS-1:0]    cl_req_valid_i,
  input  hero_pkg::cl_req_t [`HERO_N_CLUSTERS-1:0]    cl_req_i,
  output logic              [`HERO_N_CLUSTERS-1:0]    cl_ack_o,
  output hero_pkg::cl_rsp_t                           cl_rsp_o,
  output logic                                        host_req_o,
  output hero_pkg::host_req_t                         host_pl_o,
  input  logic                                        host_ack_i,
  input  logic [31:0]                                 host_rdata_i,
  input  logic                                        conf_req_i,
  input  logic [$clog2(`HERO_RAB_ENTRIES)-1:0]        conf_idx_i,
  input  hero_pkg::rab_entry_t                        conf_entry_i,
  output logic                                        conf_ack_o,
  output logic                                        rab_miss_irq_o
);

  // arbiter to router
  logic              bus_req;
  hero_pkg::cl_req_t bus_req_pl;
  logic              bus_ack;
  hero_pkg::cl_rsp_t bus_rsp;

  // router to targets
  logic              l2_req;
  hero_pkg::cl_req_t l2_pl;
  logic              l2_ack;
  logic [31:0]       l2_rdata;
  logic              rab_req;
  hero_pkg::cl_req_t rab_pl;
  logic              rab_ack;
  hero_pkg::cl_rsp_t rab_rsp;

  cl_port_arbiter #(
    .N_CLUSTERS (`HERO_N_CLUSTERS)
  ) i_arbiter (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .cl_req_valid_i (cl_req_valid_i),
    .cl_req_i       (cl_req_i),
    .cl_ack_o       (cl_ack_o),
    .cl_rsp_o       (cl_rsp_o),
    .bus_req_o      (bus_req),
    .bus_pl_o       (bus_req_pl),
    .bus_ack_i      (bus_ack),
    .bus_rsp_i      (bus_rsp)
  );

  soc_router i_router (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .bus_req_i  (bus_req),
    .bus_pl_i   (bus_req_pl),
    .bus_ack_o  (bus_ack),
    .bus_rsp_o  (bus_rsp),
    .l2_req_o   (l2_req),
    .l2_pl_o    (l2_pl),
    .l2_ack_i   (l2_ack),
    .l2_rdata_i (l2_rdata),
    .rab_req_o  (rab_req),
    .rab_pl_o   (rab_pl),
    .rab_ack_i  (rab_ack),
    .rab_rsp_i  (rab_rsp)
  );

  l2_mem i_l2_mem (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (l2_req),
    .pl_i    (l2_pl),
    .ack_o   (l2_ack),
    .rdata_o (l2_rdata)
  );

  rab i_rab (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .req_i        (rab_req),
    .pl_i         (rab_pl),
    .ack_o        (rab_ack),
    .rsp_o        (rab_rsp),
    .host_req_o   (host_req_o),
    .host_pl_o    (host_pl_o),
    .host_ack_i   (host_ack_i),
    .host_rdata_i (host_rdata_i),
    .conf_req_i   (conf_req_i),
    .conf_idx_i   (conf_idx_i),
    .conf_entry_i (conf_entry_i),
    .conf_ack_o   (conf_ack_o),
    .miss_irq_o   (rab_miss_irq_o)
  );

endmodule

//--- rtl/hero_pkg.sv
/*
 * HERO types
 * request, response, host and RAB entry structs, and the address union
 * with its L2 and RAB views
 */
package hero_pkg;

  // address as seen by the router
  typedef struct packed {
    logic [3:0]  region;
    logic [17:0] rsvd;
    logic [7:0]  word_idx;
    logic [1:0]  byte_off;
  } l2_addr_t;

  // address as seen by the RAB
  typedef struct packed {
    logic [19:0] vpn;
    logic [11:0] offset;
  } rab_addr_t;

  typedef union packed {
    l2_addr_t  l2;
    rab_addr_t rab;
  } hero_addr_u;

  typedef struct packed {
    logic        we;
    hero_addr_u  addr;
    logic [31:0] wdata;
  } cl_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        err;
  } cl_rsp_t;

  typedef struct packed {
    logic        we;
    logic [31:0] addr;
    logic [31:0] wdata;
  } host_req_t;

  typedef struct packed {
    logic        valid;
    logic [19:0] vpn;
    logic [19:0] ppn;
  } rab_entry_t;

endpackage

//--- rtl/l2_mem.sv
/*
 * L2 scratchpad
 * word-addressed single-port memory behind a req/ack port,
 * one access per handshake
 */
`timescale 1ns/1ns
`include "hero_defs.svh"

module l2_mem (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              req_i,
  input  hero_pkg::cl_req_t pl_i,
  output logic              ack_o,
  output logic [31:0]       rdata_o
);

  logic [31:0] mem_q [`HERO_L2_WORDS];
  logic        access;

  // one access per rising req
  assign access = req_i && !ack_o;

  always_ff @(posedge clk_i) begin
    if (access) begin
      if (pl_i.we) begin
        mem_q[pl_i.addr.l2.word_idx] <= pl_i.wdata;
      end else begin
        rdata_o <= mem_q[pl_i.addr.l2.word_idx];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ack_o <= 1'b0;
    end else if (access) begin
      ack_o <= 1'b1;
    end else if (!req_i) begin
      ack_o <= 1'b0;
    end
  end

endmodule

//--- rtl/rab.sv
/*
 * remapping address block
 * translates the virtual page through a host-programmed table,
 * forwards hits to the host port and flags misses with a sticky IRQ
 */
`timescale 1ns/1ns
`include "hero_defs.svh"

module rab (
  input  logic                                       clk_i,
  input  logic                                       rst_n_i,
  input  logic                                       req_i,
  input  hero_pkg::cl_req_t                          pl_i,
  output logic                                       ack_o,
  output hero_pkg::cl_rsp_t                          rsp_o,
  output logic                                       host_req_o,
  output hero_pkg::host_req_t                        host_pl_o,
  input  logic                                       host_ack_i,
  input  logic [31:0]                                host_rdata_i,
  input  logic                                       conf_req_i,
  input  logic [$clog2(`HERO_RAB_ENTRIES)-1:0]       conf_idx_i,
  input  hero_pkg::rab_entry_t                       conf_entry_i,
  output logic                                       conf_ack_o,
  output logic                                       miss_irq_o
);

  typedef enum logic [1:0] {RAB_IDLE, RAB_LOOKUP, RAB_HOST, RAB_ACK} rab_state_e;

  rab_state_e           state_q;
  hero_pkg::rab_entry_t tbl_q [`HERO_RAB_ENTRIES];
  logic                 hit;
  logic [19:0]          hit_ppn;
  logic                 conf_wr;
  logic                 miss_evt;

  // lowest matching index wins, so scan downwards
  always_comb begin
    hit     = 1'b0;
    hit_ppn = '0;
    for (int i = `HERO_RAB_ENTRIES - 1; i >= 0; i--) begin
      if (tbl_q[i].valid && tbl_q[i].vpn == pl_i.addr.rab.vpn) begin
        hit     = 1'b1;
        hit_ppn = tbl_q[i].ppn;
      end
    end
  end

  assign conf_wr  = conf_req_i && !conf_ack_o;
  assign miss_evt = state_q == RAB_LOOKUP && !hit;

  // config port
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      conf_ack_o <= 1'b0;
      for (int i = 0; i < `HERO_RAB_ENTRIES; i++) begin
        tbl_q[i].valid <= 1'b0;
      end
    end else if (conf_wr) begin
      tbl_q[conf_idx_i] <= conf_entry_i;
      conf_ack_o        <= 1'b1;
    end else if (!conf_req_i) begin
      conf_ack_o <= 1'b0;
    end
  end

  // sticky until the host reprograms the table
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      miss_irq_o <= 1'b0;
    end else if (miss_evt) begin
      miss_irq_o <= 1'b1;
    end else if (conf_wr) begin
      miss_irq_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q    <= RAB_IDLE;
      ack_o      <= 1'b0;
      host_req_o <= 1'b0;
    end else begin
      case (state_q)
        RAB_IDLE: begin
          if (req_i) begin
            state_q <= RAB_LOOKUP;
          end
        end
        RAB_LOOKUP: begin
          if (hit) begin
            host_req_o <= 1'b1;
            state_q    <= RAB_HOST;
          end else begin
            ack_o   <= 1'b1;
            state_q <= RAB_ACK;
          end
        end
        RAB_HOST: begin
          if (host_ack_i) begin
            host_req_o <= 1'b0;
            ack_o      <= 1'b1;
            state_q    <= RAB_ACK;
          end
        end
        default: begin
          if (!req_i && !host_ack_i) begin
            ack_o   <= 1'b0;
            state_q <= RAB_IDLE;
          end
        end
      endcase
    end
  end

  // host request and response payload
  always_ff @(posedge clk_i) begin
    if (state_q == RAB_LOOKUP) begin
      host_pl_o.we    <= pl_i.we;
      host_pl_o.addr  <= {hit_ppn, pl_i.addr.rab.offset};
      host_pl_o.wdata <= pl_i.wdata;
      rsp_o.rdata     <= '0;
      rsp_o.err       <= !hit;
    end else if (state_q == RAB_HOST && host_ack_i) begin
      rsp_o.rdata <= host_rdata_i;
      rsp_o.err   <= 1'b0;
    end
  end

endmodule

//--- rtl/soc_router.sv
/*
 * SoC bus router
 * decodes the address region and runs the handshake towards the L2
 * or the RAB; unmapped addresses get a local error response
 */
`timescale 1ns/1ns
`include "hero_defs.svh"

module soc_router (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              bus_req_i,
  input  hero_pkg::cl_req_t bus_pl_i,
  output logic              bus_ack_o,
  output hero_pkg::cl_rsp_t bus_rsp_o,
  output logic              l2_req_o,
  output hero_pkg::cl_req_t l2_pl_o,
  input  logic              l2_ack_i,
  input  logic [31:0]       l2_rdata_i,
  output logic              rab_req_o,
  output hero_pkg::cl_req_t rab_pl_o,
  input  logic              rab_ack_i,
  input  hero_pkg::cl_rsp_t rab_rsp_i
);

  typedef enum logic [1:0] {RT_IDLE, RT_L2, RT_RAB, RT_ACK} rt_state_e;

  rt_state_e         state_q;
  hero_pkg::cl_req_t pl_q;
  logic              sel_rab;
  logic              sel_l2;

  // top bit goes to the RAB before the region compare
  assign sel_rab = bus_pl_i.addr.l2.region[3];
  assign sel_l2  = bus_pl_i.addr.l2.region == `HERO_REGION_L2;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q   <= RT_IDLE;
      bus_ack_o <= 1'b0;
      l2_req_o  <= 1'b0;
      rab_req_o <= 1'b0;
    end else begin
      case (state_q)
        RT_IDLE: begin
          if (bus_req_i) begin
            if (sel_rab) begin
              rab_req_o <= 1'b1;
              state_q   <= RT_RAB;
            end else if (sel_l2) begin
              l2_req_o <= 1'b1;
              state_q  <= RT_L2;
            end else begin
              bus_ack_o <= 1'b1;
              state_q   <= RT_ACK;
            end
          end
        end
        RT_L2: begin
          if (l2_ack_i) begin
            l2_req_o  <= 1'b0;
            bus_ack_o <= 1'b1;
            state_q   <= RT_ACK;
          end
        end
        RT_RAB: begin
          if (rab_ack_i) begin
            rab_req_o <= 1'b0;
            bus_ack_o <= 1'b1;
            state_q   <= RT_ACK;
          end
        end
        default: begin
          // wait for the requester and the target to close
          if (!bus_req_i && !l2_ack_i && !rab_ack_i) begin
            bus_ack_o <= 1'b0;
            state_q   <= RT_IDLE;
          end
        end
      endcase
    end
  end

  // response and target payload
  always_ff @(posedge clk_i) begin
    if (state_q == RT_IDLE && bus_req_i) begin
      pl_q            <= bus_pl_i;
      bus_rsp_o.rdata <= '0;
      bus_rsp_o.err   <= !sel_rab && !sel_l2;
    end else if (state_q == RT_L2 && l2_ack_i) begin
      bus_rsp_o.rdata <= l2_rdata_i;
      bus_rsp_o.err   <= 1'b0;
    end else if (state_q == RT_RAB && rab_ack_i) begin
      bus_rsp_o <= rab_rsp_i;
    end
  end

  assign l2_pl_o  = pl_q;
  assign rab_pl_o = pl_q;

endmodule

//--- tb.f
+incdir+include
rtl/hero_pkg.sv
rtl/cl_port_arbiter.sv
rtl/soc_router.sv
rtl/l2_mem.sv
rtl/rab.sv
rtl/hero.sv
verif/tb_hero.sv

//--- verif/tb_hero.sv
/*
 * HERO SoC testbench
 * directed tests on the cluster ports, with a reactive host memory model
 * behind the RAB and a config port driver
 */
`timescale 1ns/1ns
`include "hero_defs.svh"

module tb_hero;

  localparam int TIMEOUT_CYCLES = 3000;
  localparam int NC = `HERO_N_CLUSTERS;

  logic                                 clk_i;
  logic                                 rst_n_i;
  logic              [NC-1:0]           cl_req_valid_i;
  hero_pkg::cl_req_t [NC-1:0]           cl_req_i;
  logic              [NC-1:0]           cl_ack_o;
  hero_pkg::cl_rsp_t                    cl_rsp_o;
  logic                                 host_req_o;
  hero_pkg::host_req_t                  host_pl_o;
  logic                                 host_ack_i;
  logic [31:0]                          host_rdata_i;
  logic                                 conf_req_i;
  logic [$clog2(`HERO_RAB_ENTRIES)-1:0] conf_idx_i;
  hero_pkg::rab_entry_t                 conf_entry_i;
  logic                                 conf_ack_o;
  logic                                 rab_miss_irq_o;

  int          n_errors = 0;
  int          n_checks = 0;
  int          cycle_cnt = 0;
  int          seed = 74770;
  int          host_extra = 0;
  int          done_order[$];
  logic [31:0] host_mem [64];
  logic [31:0] host_last_addr;
  logic [31:0] l2_exp [`HERO_L2_WORDS];

  hero hero_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES) begin
      $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // host memory that acks after a random 0 to 3 cycles plus any extra stall
  initial begin : host_model
    int delay;
    for (int i = 0; i < 64; i++) begin
      host_mem[i] = 32'hc0de_0000 + i;
    end
    forever begin
      @(posedge clk_i);
      if (host_req_o && !host_ack_i) begin
        delay = host_extra + ($unsigned($random(seed)) % 4);
        repeat (delay) @(posedge clk_i);
        host_last_addr = host_pl_o.addr;
        if (host_pl_o.we) begin
          host_mem[host_pl_o.addr[7:2]] = host_pl_o.wdata;
        end
        host_rdata_i <= host_mem[host_pl_o.addr[7:2]];
        host_ack_i   <= 1'b1;
        do @(posedge clk_i); while (host_req_o);
        host_ack_i <= 1'b0;
      end
    end
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    n_checks++;
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
      n_errors++;
    end
  endtask

  // region 1 address with the word index in bits 9..2
  function automatic logic [31:0] l2_addr(input logic [7:0] idx);
    return {`HERO_REGION_L2, 18'h0, idx, 2'b00};
  endfunction

  task automatic cluster_access(input int c, input logic we, input logic [31:0] addr,
                                input logic [31:0] wdata, output hero_pkg::cl_rsp_t rsp);
    hero_pkg::cl_req_t pl;
    pl.we    = we;
    pl.addr  = addr;
    pl.wdata = wdata;
    @(posedge clk_i);
    cl_req_i[c]       <= pl;
    cl_req_valid_i[c] <= 1'b1;
    do @(posedge clk_i); while (!cl_ack_o[c]);
    rsp = cl_rsp_o;
    done_order.push_back(c);
    cl_req_valid_i[c] <= 1'b0;
    do @(posedge clk_i); while (cl_ack_o[c]);
  endtask

  task automatic program_entry(input logic [$clog2(`HERO_RAB_ENTRIES)-1:0] idx,
                               input logic [19:0] vpn, input logic [19:0] ppn);
    hero_pkg::rab_entry_t e;
    e.valid = 1'b1;
    e.vpn   = vpn;
    e.ppn   = ppn;
    @(posedge clk_i);
    conf_idx_i   <= idx;
    conf_entry_i <= e;
    conf_req_i   <= 1'b1;
    do @(posedge clk_i); while (!conf_ack_o);
    conf_req_i <= 1'b0;
    do @(posedge clk_i); while (conf_ack_o);
  endtask

  // all clusters at once from pointer 0 after reset
  task automatic round_robin_order;
    hero_pkg::cl_rsp_t rsp [NC];
    for (int pass = 0; pass < 2; pass++) begin
      done_order.delete();
      fork
        cluster_access(0, pass == 0, l2_addr(8'd8), 32'h5500_0000, rsp[0]);
        cluster_access(1, pass == 0, l2_addr(8'd9), 32'h5500_0001, rsp[1]);
        cluster_access(2, pass == 0, l2_addr(8'd10), 32'h5500_0002, rsp[2]);
        cluster_access(3, pass == 0, l2_addr(8'd11), 32'h5500_0003, rsp[3]);
      join
      for (int c = 0; c < NC; c++) begin
        l2_exp[8 + c] = 32'h5500_0000 + c;
        check_value("completion order", done_order[c], c);
        check_value("cl_rsp_o.err", rsp[c].err, 0);
        if (pass == 1) begin
          check_value("cl_rsp_o.rdata", rsp[c].rdata, l2_exp[8 + c]);
        end
      end
    end
  endtask

  task automatic l2_write_read;
    hero_pkg::cl_rsp_t rsp;
    logic [7:0]        idx;
    // every word written before any read back
    for (int k = 0; k < NC; k++) begin
      idx = 8'(8'h20 + 8'h35 * k);
      l2_exp[idx] = 32'hdead_0000 ^ (32'h0101_1111 * (k + 1));
      cluster_access(k, 1'b1, l2_addr(idx), l2_exp[idx], rsp);
      check_value("cl_rsp_o.err", rsp.err, 0);
    end
    for (int k = 0; k < NC; k++) begin
      idx = 8'(8'h20 + 8'h35 * k);
      cluster_access((k + 1) % NC, 1'b0, l2_addr(idx), 32'h0, rsp);
      check_value("cl_rsp_o.rdata", rsp.rdata, l2_exp[idx]);
      check_value("cl_rsp_o.err", rsp.err, 0);
    end
  endtask

  task automatic unmapped_error;
    hero_pkg::cl_rsp_t rsp;
    cluster_access(1, 1'b0, 32'h3000_0000, 32'h0, rsp);
    check_value("cl_rsp_o.err", rsp.err, 1);
    check_value("cl_rsp_o.rdata", rsp.rdata, 0);
    check_value("rab_miss_irq_o", rab_miss_irq_o, 0);
  endtask

  // vpn 0x80001 maps to ppn 0x00042
  task automatic rab_translate;
    hero_pkg::cl_rsp_t rsp;
    program_entry(0, 20'h80001, 20'h00042);
    cluster_access(2, 1'b0, 32'h8000_1010, 32'h0, rsp);
    check_value("host_pl_o.addr", host_last_addr, 32'h0004_2010);
    check_value("cl_rsp_o.rdata", rsp.rdata, 32'hc0de_0004);
    check_value("cl_rsp_o.err", rsp.err, 0);
    cluster_access(3, 1'b1, 32'h8000_1014, 32'h1234_5678, rsp);
    check_value("host_pl_o.addr", host_last_addr, 32'h0004_2014);
    check_value("host memory word 5", host_mem[5], 32'h1234_5678);
    check_value("cl_rsp_o.err", rsp.err, 0);
  endtask

  task automatic rab_miss_irq;
    hero_pkg::cl_rsp_t rsp;
    cluster_access(0, 1'b0, 32'h8000_5000, 32'h0, rsp);
    check_value("cl_rsp_o.err", rsp.err, 1);
    check_value("cl_rsp_o.rdata", rsp.rdata, 0);
    check_value("rab_miss_irq_o", rab_miss_irq_o, 1);
    cluster_access(1, 1'b0, l2_addr(8'd8), 32'h0, rsp);
    check_value("rab_miss_irq_o", rab_miss_irq_o, 1);
    program_entry(1, 20'h80005, 20'h00043);
    check_value("rab_miss_irq_o", rab_miss_irq_o, 0);
  endtask

  // slow host holds cluster 2 behind cluster 1
  task automatic host_backpressure;
    hero_pkg::cl_rsp_t rsp_slow;
    hero_pkg::cl_rsp_t rsp_l2;
    host_extra = 12;
    done_order.delete();
    fork
      cluster_access(1, 1'b0, 32'h8000_1018, 32'h0, rsp_slow);
      begin
        do @(posedge clk_i); while (!host_req_o);
        cluster_access(2, 1'b0, l2_addr(8'd10), 32'h0, rsp_l2);
      end
    join
    host_extra = 0;
    check_value("completion order", done_order[0], 1);
    check_value("completion order", done_order[1], 2);
    check_value("cl_rsp_o.rdata", rsp_slow.rdata, 32'hc0de_0006);
    check_value("cl_rsp_o.err", rsp_slow.err, 0);
    check_value("cl_rsp_o.rdata", rsp_l2.rdata, l2_exp[10]);
    check_value("cl_rsp_o.err", rsp_l2.err, 0);
  endtask

  initial begin
    rst_n_i        = 1'b0;
    cl_req_valid_i = '0;
    cl_req_i       = '0;
    host_ack_i     = 1'b0;
    host_rdata_i   = '0;
    conf_req_i     = 1'b0;
    conf_idx_i     = '0;
    conf_entry_i   = '0;
    repeat (5) @(posedge clk_i);
    rst_n_i <= 1'b1;
    round_robin_order();
    l2_write_read();
    unmapped_error();
    rab_translate();
    rab_miss_irq();
    host_backpressure();
    repeat (2) @(posedge clk_i);
    $display("checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule
